// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := uart_bridge_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
# Keep running after an assertion error so the testbench can report the failure
SIMARGS   := +verilator+error+limit+100

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) hw/uart_bridge_defs.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) $(SIMARGS) 2>&1 | tee $(LOG)
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/uart_bridge_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_bridge_asserts (
   input logic                         clk,
   input logic                         c_ex_rst,
   input logic                         uart_tx,
   input logic                         tx_busy,
   input uart_bridge_pkg::bus_rd_req_t slv_rd_req,
   input uart_bridge_pkg::bus_rd_rsp_t slv_rd_rsp,
   input uart_bridge_pkg::mem_wr_t     mem_wr
);

   int unsigned fail_count = 0;

   // Memory write is a single-cycle pulse
   a_mem_wr_pulse: assert property (@(posedge clk) disable iff (c_ex_rst)
      mem_wr.valid |=> !mem_wr.valid)
      else begin
         fail_count++;
         $error("mem_wr.valid high in two consecutive cycles");
      end

   a_rd_ready: assert property (@(posedge clk) disable iff (c_ex_rst)
      slv_rd_rsp.ready |-> slv_rd_req.valid)
      else begin
         fail_count++;
         $error("slv_rd_rsp.ready without a valid read request");
      end

   // Line idles high whenever the transmitter is free
   a_tx_idle: assert property (@(posedge clk) disable iff (c_ex_rst)
      !tx_busy |-> uart_tx)
      else begin
         fail_count++;
         $error("uart_tx low while tx_busy is low");
      end

endmodule

bind uart_bridge_top uart_bridge_asserts i_uart_bridge_asserts (
   .clk        (clk),
   .c_ex_rst   (c_ex_rst),
   .uart_tx    (uart_tx),
   .tx_busy    (tx_busy),
   .slv_rd_req (slv_rd_req),
   .slv_rd_rsp (slv_rd_rsp),
   .mem_wr     (mem_wr)
);

`default_nettype wire

// ==== dv/uart_bridge_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_bridge_defs.svh"

module uart_bridge_tb;

   localparam int BIT_CYC = `UART_BAUD_FULL + 1;
   localparam int N_COM   = 4;
   // Two reset commands, memory write, transmit frame, mode byte, com bytes
   localparam int N_FRAMES = 2 + 7 + 1 + 1 + N_COM;
   localparam longint TIMEOUT_NS = longint'(N_FRAMES) * 10 * BIT_CYC * 20 + 100000;

   logic                         clk;
   logic                         c_ex_rst;
   logic                         uart_rx;
   logic                         uart_tx;
   logic                         user_rst;
   uart_bridge_pkg::bus_wr_t     slv_wr;
   uart_bridge_pkg::bus_rd_req_t slv_rd_req;
   uart_bridge_pkg::bus_rd_rsp_t slv_rd_rsp;
   uart_bridge_pkg::mem_wr_t     mem_wr;

   // Model of the DUT status
   logic                         exp_tx_busy;
   logic                         exp_rx_flag;
   logic [7:0]                   exp_rx_data;
   int                           wr_count;
   uart_bridge_pkg::mem_wr_t     wr_seen;

   uart_bridge_top i_uart_bridge_top (
      .clk        (clk),
      .c_ex_rst   (c_ex_rst),
      .uart_rx    (uart_rx),
      .uart_tx    (uart_tx),
      .user_rst   (user_rst),
      .slv_wr     (slv_wr),
      .slv_rd_req (slv_rd_req),
      .slv_rd_rsp (slv_rd_rsp),
      .mem_wr     (mem_wr)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   always @(negedge clk) begin
      if (mem_wr.valid) begin
         wr_count++;
         wr_seen = mem_wr;
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout after %0d ns, the test did not finish", TIMEOUT_NS);
      $display("*** FAILED ***");
      $fatal(1, "Watchdog expired");
   end

   // -------------------------------------------------------------------------
   // Checking
   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1, "Stopping at the first error");
   endtask

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      if (got !== exp) begin
         fail_run($sformatf("Mismatch at %0t ns: %s got 0x%08h expected 0x%08h",
                            $time, what, got, exp));
      end
   endtask

   function automatic uart_bridge_pkg::bus_rd_rsp_t expected_read(input logic [31:0] addr);
      uart_bridge_pkg::bus_rd_rsp_t rsp;
      rsp = '0;
      rsp.ready = 1'b1;
      case (addr)
         `UART_ADDR_TX_BUSY: rsp.data[0] = exp_tx_busy;
         `UART_ADDR_RX_FLAG: rsp.data[0] = exp_rx_flag;
         `UART_ADDR_RX_DATA: rsp.data[7:0] = exp_rx_data;
         default: rsp.ready = 1'b0;
      endcase
      return rsp;
   endfunction

   // -------------------------------------------------------------------------
   // Bus and serial models
   task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
      @(negedge clk);
      slv_wr.valid = 1'b1;
      slv_wr.addr  = addr;
      slv_wr.data  = data;
      @(negedge clk);
      slv_wr.valid = 1'b0;
   endtask

   // Response sampled mid-cycle, before the edge that sees the request
   task automatic bus_read(input logic [31:0] addr, output uart_bridge_pkg::bus_rd_rsp_t rsp);
      @(negedge clk);
      slv_rd_req.valid = 1'b1;
      slv_rd_req.addr  = addr;
      #5;
      rsp = slv_rd_rsp;
      @(negedge clk);
      slv_rd_req.valid = 1'b0;
   endtask

   task automatic check_read(input logic [31:0] addr, input string what);
      uart_bridge_pkg::bus_rd_rsp_t rsp;
      uart_bridge_pkg::bus_rd_rsp_t exp;
      exp = expected_read(addr);
      bus_read(addr, rsp);
      check_value(32'(rsp.ready), 32'(exp.ready), {what, " ready"});
      check_value(rsp.data, exp.data, {what, " data"});
      if (exp.ready && addr == `UART_ADDR_RX_DATA) begin
         exp_rx_flag = 1'b0;
      end
   endtask

   task automatic wait_read_bit(input logic [31:0] addr, input logic value, input int max_reads);
      uart_bridge_pkg::bus_rd_rsp_t rsp;
      int                           n;
      n = 0;
      bus_read(addr, rsp);
      while (rsp.data[0] !== value) begin
         n++;
         if (n > max_reads) begin
            fail_run($sformatf("Read of 0x%08h never returned %0d", addr, value));
         end
         bus_read(addr, rsp);
      end
   endtask

   task automatic wait_user_rst(input logic value, input int max_cycles);
      int n;
      n = 0;
      while (user_rst !== value) begin
         if (n == max_cycles) begin
            fail_run($sformatf("user_rst did not go to %0d within %0d cycles",
                               value, max_cycles));
         end
         n++;
         @(negedge clk);
      end
   endtask

   // Start bit, eight data bits LSB first, stop bit
   task automatic send_byte(input logic [7:0] b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(negedge clk);
         uart_rx = frame[i];
         repeat (BIT_CYC - 1) @(negedge clk);
      end
   endtask

   task automatic receive_byte(output logic [7:0] b, output logic start_bit,
                               output logic stop_bit);
      @(negedge uart_tx);
      repeat (BIT_CYC / 2) @(negedge clk);
      start_bit = uart_tx;
      for (int i = 0; i < 8; i++) begin
         repeat (BIT_CYC) @(negedge clk);
         b[i] = uart_tx;
      end
      repeat (BIT_CYC) @(negedge clk);
      stop_bit = uart_tx;
   endtask

   // -------------------------------------------------------------------------
   // Test sequence
   initial begin
      logic [7:0]  mem_bytes [6];
      logic [7:0]  txb;
      logic [7:0]  rxb;
      logic        start_bit;
      logic        stop_bit;

      void'($urandom(14694));
      wr_count    = 0;
      exp_tx_busy = 1'b0;
      exp_rx_flag = 1'b0;
      exp_rx_data = 8'h00;
      c_ex_rst    = 1'b1;
      uart_rx     = 1'b1;
      slv_wr      = '0;
      slv_rd_req  = '0;
      repeat (3) @(negedge clk);
      c_ex_rst = 1'b0;
      @(negedge clk);

      check_value(32'(uart_tx), 32'd1, "uart_tx after reset");
      check_value(32'(user_rst), 32'd1, "user_rst after reset");
      check_value(32'(mem_wr.valid), 32'd0, "mem_wr.valid after reset");
      check_read(`UART_ADDR_TX_BUSY, "busy after reset");

      send_byte(`UART_CMD_RST_CLR);
      wait_user_rst(1'b0, 2 * BIT_CYC);
      send_byte(`UART_CMD_RST_SET);
      wait_user_rst(1'b1, 2 * BIT_CYC);

      // Two address bytes then four data bytes
      for (int i = 0; i < 6; i++) begin
         mem_bytes[i] = 8'($urandom);
      end
      wr_count = 0;
      send_byte(`UART_CMD_PROG_MEM);
      for (int i = 0; i < 6; i++) begin
         send_byte(mem_bytes[i]);
      end
      repeat (BIT_CYC) @(negedge clk);
      check_value(wr_count, 32'd1, "memory write count");
      check_value(wr_seen.addr, {16'h0000, mem_bytes[1], mem_bytes[0]}, "memory write addr");
      check_value(wr_seen.data, {mem_bytes[5], mem_bytes[4], mem_bytes[3], mem_bytes[2]},
                  "memory write data");

      txb         = 8'($urandom);
      exp_tx_busy = 1'b1;
      fork
         receive_byte(rxb, start_bit, stop_bit);
         begin
            bus_write(`UART_ADDR_TX_DATA, {24'h000000, txb});
            check_read(`UART_ADDR_TX_BUSY, "busy after transmit write");
         end
      join
      check_value(32'(start_bit), 32'd0, "transmit start bit");
      check_value(32'(rxb), 32'(txb), "transmit data");
      check_value(32'(stop_bit), 32'd1, "transmit stop bit");
      exp_tx_busy = 1'b0;
      wait_read_bit(`UART_ADDR_TX_BUSY, 1'b0, BIT_CYC);
      check_read(`UART_ADDR_TX_BUSY, "busy after frame");

      send_byte(`UART_CMD_COM_MODE);
      check_read(`UART_ADDR_RX_FLAG, "flag after mode entry");
      for (int i = 0; i < N_COM; i++) begin
         txb = 8'($urandom);
         send_byte(txb);
         exp_rx_flag = 1'b1;
         exp_rx_data = txb;
         check_read(`UART_ADDR_RX_FLAG, "flag after byte");
         check_read(`UART_ADDR_RX_DATA, "received data");
         check_read(`UART_ADDR_RX_FLAG, "flag after data read");
      end
      check_read(32'h8002_0040, "unmapped read");

      if (i_uart_bridge_top.i_uart_bridge_asserts.fail_count == 0) begin
         $display("*** PASSED ***");
         $finish;
      end
      else begin
         $display("Run ended with %0d assertion failures",
                  i_uart_bridge_top.i_uart_bridge_asserts.fail_count);
         $display("*** FAILED ***");
         $fatal(1, "Errors during the run");
      end
   end

endmodule

`default_nettype wire

// ==== hw/uart_bridge_defs.svh ====
`ifndef UART_BRIDGE_DEFS_SVH
`define UART_BRIDGE_DEFS_SVH

// Bit period of 291 clocks, counter runs 0 to 290
`define UART_BAUD_FULL 290
`define UART_BAUD_HALF 145

// Slave register map
`define UART_ADDR_TX_DATA 32'h8002_0000
`define UART_ADDR_TX_BUSY 32'h8002_0010
`define UART_ADDR_RX_DATA 32'h8002_0020
`define UART_ADDR_RX_FLAG 32'h8002_0030

// Command bytes seen by the decoder
`define UART_CMD_RST_CLR  8'h10
`define UART_CMD_RST_SET  8'h11
`define UART_CMD_PROG_MEM 8'h30
`define UART_CMD_COM_MODE 8'h50

`define BUS_W 32

`endif

// ==== hw/uart_bridge_pkg.sv ====
`default_nettype none

`include "uart_bridge_defs.svh"

package uart_bridge_pkg;

   typedef struct packed {
      logic              valid;
      logic [`BUS_W-1:0] addr;
      logic [`BUS_W-1:0] data;
   } bus_wr_t;

   typedef struct packed {
      logic              valid;
      logic [`BUS_W-1:0] addr;
   } bus_rd_req_t;

   typedef struct packed {
      logic              ready;
      logic [`BUS_W-1:0] data;
   } bus_rd_rsp_t;

   // Upper half of addr always zero
   typedef struct packed {
      logic              valid;
      logic [`BUS_W-1:0] addr;
      logic [`BUS_W-1:0] data;
   } mem_wr_t;

   typedef struct packed {
      logic       valid;
      logic [7:0] data;
   } rx_byte_t;

endpackage

`default_nettype wire

// ==== hw/uart_bridge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_bridge_top (
   input  logic                         clk,
   input  logic                         c_ex_rst,
   input  logic                         uart_rx,
   output logic                         uart_tx,
   output logic                         user_rst,
   input  uart_bridge_pkg::bus_wr_t     slv_wr,
   input  uart_bridge_pkg::bus_rd_req_t slv_rd_req,
   output uart_bridge_pkg::bus_rd_rsp_t slv_rd_rsp,
   output uart_bridge_pkg::mem_wr_t     mem_wr
);

   uart_bridge_pkg::rx_byte_t rx_byte;
   uart_bridge_pkg::rx_byte_t com_byte;
   logic                      tx_load;
   logic [7:0]                tx_byte;
   logic                      tx_busy;
   logic                      rx_data_rd;
   logic                      rx_flag;
   logic [7:0]                rx_data;

   uart_rx i_uart_rx (
      .clk      (clk),
      .c_ex_rst (c_ex_rst),
      .uart_rx  (uart_rx),
      .rx_byte  (rx_byte)
   );

   uart_tx i_uart_tx (
      .clk      (clk),
      .c_ex_rst (c_ex_rst),
      .tx_load  (tx_load),
      .tx_byte  (tx_byte),
      .uart_tx  (uart_tx),
      .tx_busy  (tx_busy)
   );

   uart_cmd_decoder i_uart_cmd_decoder (
      .clk        (clk),
      .c_ex_rst   (c_ex_rst),
      .rx_byte    (rx_byte),
      .rx_data_rd (rx_data_rd),
      .user_rst   (user_rst),
      .mem_wr     (mem_wr),
      .com_byte   (com_byte),
      .rx_flag    (rx_flag),
      .rx_data    (rx_data)
   );

   uart_bus_regs i_uart_bus_regs (
      .slv_wr     (slv_wr),
      .slv_rd_req (slv_rd_req),
      .slv_rd_rsp (slv_rd_rsp),
      .tx_busy    (tx_busy),
      .rx_flag    (rx_flag),
      .rx_data    (rx_data),
      .com_byte   (com_byte),
      .tx_load    (tx_load),
      .tx_byte    (tx_byte),
      .rx_data_rd (rx_data_rd)
   );

endmodule

`default_nettype wire

// ==== hw/uart_bus_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_bridge_defs.svh"

module uart_bus_regs (
   input  uart_bridge_pkg::bus_wr_t     slv_wr,
   input  uart_bridge_pkg::bus_rd_req_t slv_rd_req,
   output uart_bridge_pkg::bus_rd_rsp_t slv_rd_rsp,
   input  logic                         tx_busy,
   input  logic                         rx_flag,
   input  logic [7:0]                   rx_data,
   input  uart_bridge_pkg::rx_byte_t    com_byte,
   output logic                         tx_load,
   output logic [7:0]                   tx_byte,
   output logic                         rx_data_rd
);

   logic tx_busy_rd;
   logic rx_flag_rd;

   // Write side, only the transmit register is mapped
   assign tx_load = slv_wr.valid && (slv_wr.addr == `UART_ADDR_TX_DATA);
   assign tx_byte = slv_wr.data[7:0];

   assign tx_busy_rd = slv_rd_req.valid && (slv_rd_req.addr == `UART_ADDR_TX_BUSY);
   assign rx_flag_rd = slv_rd_req.valid && (slv_rd_req.addr == `UART_ADDR_RX_FLAG);
   assign rx_data_rd = slv_rd_req.valid && (slv_rd_req.addr == `UART_ADDR_RX_DATA);

   //--------------------------------------------------------------------------
   // Read mux, zero extended
   always_comb begin
      slv_rd_rsp.ready = tx_busy_rd | rx_flag_rd | rx_data_rd;
      slv_rd_rsp.data  = '0;
      if (tx_busy_rd) begin
         slv_rd_rsp.data[0] = tx_busy;
      end
      else if (rx_flag_rd) begin
         slv_rd_rsp.data[0] = rx_flag | com_byte.valid;
      end
      else if (rx_data_rd) begin
         // Bypass a byte arriving in the same cycle
         slv_rd_rsp.data[7:0] = com_byte.valid ? com_byte.data : rx_data;
      end
   end

endmodule

`default_nettype wire

// ==== hw/uart_cmd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_bridge_defs.svh"

module uart_cmd_decoder (
   input  logic                      clk,
   input  logic                      c_ex_rst,
   input  uart_bridge_pkg::rx_byte_t rx_byte,
   input  logic                      rx_data_rd,
   output logic                      user_rst,
   output uart_bridge_pkg::mem_wr_t  mem_wr,
   output uart_bridge_pkg::rx_byte_t com_byte,
   output logic                      rx_flag,
   output logic [7:0]                rx_data
);

   typedef enum logic [2:0] {
      CMD_EXEC,
      CMD_ADD_B0,
      CMD_ADD_B1,
      CMD_DAT_B0,
      CMD_DAT_B1,
      CMD_DAT_B2,
      CMD_DAT_B3,
      CMD_COM_MODE
   } cmd_state_t;

   cmd_state_t  state;
   logic [15:0] wr_addr;
   logic [23:0] wr_data;

   always_ff @(posedge clk or posedge c_ex_rst) begin
      if (c_ex_rst) begin
         state    <= CMD_EXEC;
         user_rst <= 1'b1;
      end
      else if (rx_byte.valid) begin
         case (state)
            CMD_EXEC: begin
               case (rx_byte.data)
                  `UART_CMD_RST_SET:  user_rst <= 1'b1;
                  `UART_CMD_RST_CLR:  user_rst <= 1'b0;
                  `UART_CMD_PROG_MEM: state <= CMD_ADD_B0;
                  `UART_CMD_COM_MODE: state <= CMD_COM_MODE;
                  default: ;
               endcase
            end
            CMD_ADD_B0: state <= CMD_ADD_B1;
            CMD_ADD_B1: state <= CMD_DAT_B0;
            CMD_DAT_B0: state <= CMD_DAT_B1;
            CMD_DAT_B1: state <= CMD_DAT_B2;
            CMD_DAT_B2: state <= CMD_DAT_B3;
            CMD_DAT_B3: state <= CMD_EXEC;
            // No way out of communication mode
            default: ;
         endcase
      end
   end

   //--------------------------------------------------------------------------
   // Memory write assembly, LSB first
   always_ff @(posedge clk) begin
      if (rx_byte.valid) begin
         case (state)
            CMD_ADD_B0: wr_addr[7:0]   <= rx_byte.data;
            CMD_ADD_B1: wr_addr[15:8]  <= rx_byte.data;
            CMD_DAT_B0: wr_data[7:0]   <= rx_byte.data;
            CMD_DAT_B1: wr_data[15:8]  <= rx_byte.data;
            CMD_DAT_B2: wr_data[23:16] <= rx_byte.data;
            default: ;
         endcase
      end
   end

   assign mem_wr.valid = (state == CMD_DAT_B3) && rx_byte.valid;
   assign mem_wr.addr  = {16'h0000, wr_addr};
   assign mem_wr.data  = {rx_byte.data, wr_data};

   //--------------------------------------------------------------------------
   // Communication mode receive register
   assign com_byte.valid = (state == CMD_COM_MODE) && rx_byte.valid;
   assign com_byte.data  = rx_byte.data;

   always_ff @(posedge clk or posedge c_ex_rst) begin
      if (c_ex_rst) begin
         rx_flag <= 1'b0;
         rx_data <= 8'h00;
      end
      else begin
         if (com_byte.valid) begin
            rx_data <= com_byte.data;
         end
         // A read in the arrival cycle already got the new byte
         rx_flag <= (rx_flag | com_byte.valid) & ~rx_data_rd;
      end
   end

endmodule

`default_nettype wire

// ==== hw/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_bridge_defs.svh"

module uart_rx (
   input  logic                      clk,
   input  logic                      c_ex_rst,
   input  logic                      uart_rx,
   output uart_bridge_pkg::rx_byte_t rx_byte
);

   typedef enum logic [1:0] {
      RX_WAIT,
      RX_START,
      RX_SHIFT,
      RX_STOP
   } rx_state_t;

   rx_state_t  state;
   logic [2:0] nrx_filt;
   logic       line_low;
   logic [8:0] baud;
   logic [7:0] shreg;
   logic       baud_full;
   logic       baud_half;

   assign baud_full = (baud == 9'(`UART_BAUD_FULL));
   assign baud_half = (baud == 9'(`UART_BAUD_HALF));

   //--------------------------------------------------------------------------
   // Input filter, inverted line and 2-of-3 vote
   always_ff @(posedge clk or posedge c_ex_rst) begin
      if (c_ex_rst) begin
         nrx_filt <= 3'b000;
         line_low <= 1'b0;
      end
      else begin
         nrx_filt <= {nrx_filt[1:0], ~uart_rx};
         line_low <= (nrx_filt[0] & nrx_filt[1]) | (nrx_filt[0] & nrx_filt[2]) |
                     (nrx_filt[1] & nrx_filt[2]);
      end
   end

   //--------------------------------------------------------------------------
   // Frame FSM
   always_ff @(posedge clk or posedge c_ex_rst) begin
      if (c_ex_rst) begin
         state <= RX_WAIT;
         baud  <= '0;
      end
      else begin
         case (state)
            RX_WAIT: begin
               baud <= '0;
               // All three samples low
               if (nrx_filt == 3'b111) begin
                  state <= RX_START;
               end
            end
            RX_START: begin
               baud <= baud + 9'd1;
               if (baud_half) begin
                  baud  <= '0;
                  state <= RX_SHIFT;
               end
            end
            RX_SHIFT: begin
               baud <= baud + 9'd1;
               if (baud_full) begin
                  baud <= '0;
                  // Sentinel in bit 0 means this is the eighth sample
                  if (shreg[0]) begin
                     state <= RX_STOP;
                  end
               end
            end
            default: begin
               baud <= baud + 9'd1;
               if (baud_full) begin
                  state <= RX_WAIT;
               end
            end
         endcase
      end
   end

   // LSB first, sentinel drops out on the last sample
   always_ff @(posedge clk) begin
      if (state == RX_WAIT) begin
         shreg <= 8'h80;
      end
      else if (state == RX_SHIFT && baud_full) begin
         shreg <= {~line_low, shreg[7:1]};
      end
   end

   assign rx_byte.valid = (state == RX_STOP) && baud_full;
   assign rx_byte.data  = shreg;

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_bridge_defs.svh"

module uart_tx (
   input  logic       clk,
   input  logic       c_ex_rst,
   input  logic       tx_load,
   input  logic [7:0] tx_byte,
   output logic       uart_tx,
   output logic       tx_busy
);

   typedef enum logic [1:0] {
      TX_WAIT,
      TX_START,
      TX_SHIFT,
      TX_STOP
   } tx_state_t;

   tx_state_t  state;
   logic [8:0] shreg;
   logic [8:0] baud;
   logic       baud_full;

   assign baud_full = (baud == 9'(`UART_BAUD_FULL));

   always_ff @(posedge clk or posedge c_ex_rst) begin
      if (c_ex_rst) begin
         state <= TX_WAIT;
         baud  <= '0;
      end
      else begin
         baud <= baud_full ? 9'd0 : baud + 9'd1;
         case (state)
            TX_WAIT: begin
               baud <= '0;
               if (tx_load) begin
                  state <= TX_START;
               end
            end
            TX_START: if (baud_full) state <= TX_SHIFT;
            // Only the stop sentinel left, its first cycle is already the stop bit
            TX_SHIFT: if (shreg == 9'h001) state <= TX_STOP;
            default:  if (baud_full) state <= TX_WAIT;
         endcase
      end
   end

   // Holding register, a new write replaces it even mid-frame
   always_ff @(posedge clk) begin
      if (state == TX_SHIFT && baud_full) begin
         shreg <= {1'b0, shreg[8:1]};
      end
      if (tx_load) begin
         shreg <= {1'b1, tx_byte};
      end
   end

   assign uart_tx = (state == TX_START) ? 1'b0 :
                    (state == TX_SHIFT) ? shreg[0] : 1'b1;
   assign tx_busy = (state != TX_WAIT);

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hw
hw/uart_bridge_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/uart_cmd_decoder.sv
hw/uart_bus_regs.sv
hw/uart_bridge_top.sv
dv/uart_bridge_asserts.sv
dv/uart_bridge_tb.sv
